//--- include/obj_defs.svh
// sprite line table sizes
// frame table geometry, line bank geometry and tile size in pixels

`ifndef OBJ_DEFS_SVH
`define OBJ_DEFS_SVH

// frame table, four words per record
`define OBJ_REC_N    256
`define OBJ_FRAME_AW 10

// one line bank
`define OBJ_LINE_N   128
`define OBJ_LINE_AW  7

// square tiles
`define OBJ_TILE_PX  16

`endif

//--- src/obj_types_pkg.sv
// sprite data types
// frame table attribute word and the 48-bit line buffer entry

package obj_types_pkg;

    // attribute word as stored in the frame table
    typedef struct packed {
        logic [3:0] tile_m;   // extra rows
        logic [3:0] tile_n;   // extra columns
        logic       spare;
        logic       vflip;
        logic       hflip;
        logic [4:0] pal;
    } obj_attr_t;

    // one entry of a line bank, read by the renderer
    typedef struct packed {
        logic [15:0] info;    // {4'd0, vsub, attr[7:0]}
        logic [15:0] code;    // tile code with row and column applied
        logic [15:0] x;       // tile x position
    } line_entry_t;

    // unused slot marker
    localparam line_entry_t LINE_FILL = '1;

endpackage

//--- src/obj_ctrl_pkg.sv
// line scanner control types
// one state per frame word fetch, then check, tile write and fill

package obj_ctrl_pkg;

    typedef enum logic [3:0] {
        idle,
        rd_attr,
        rd_code,
        rd_y,
        rd_x,
        check,    // zone and repeat test
        write,    // one entry per tile
        next,
        fill      // pad bank with all ones
    } scan_st_t;

endpackage

//--- src/obj_ram.sv
// simple dual-port memory with registered read
// word type is a parameter so one block serves frame words and line entries

module obj_ram #(
    parameter type word_t = logic [15:0],
    parameter int  aw     = 10
) (
    input  logic          clk,
    input  logic          we,
    input  logic [aw-1:0] waddr,
    input  word_t         wdata,
    input  logic [aw-1:0] raddr,
    output word_t         rdata
);

    word_t mem [0:(1 << aw) - 1];

    always_ff @(posedge clk) begin
        if (we) begin
            mem[waddr] <= wdata;
        end
        rdata <= mem[raddr];  // one cycle latency
    end

    // an unknown write address would corrupt an unknown word
    a_waddr_known: assert property (
        @(posedge clk) we |-> !$isunknown(waddr)
    );

endmodule

//--- src/obj_vmatch.sv
// vertical hit test for one sprite record
// finds the tile row that covers the render line and builds the tile code

`include "obj_defs.svh"

module obj_vmatch (
    input  logic [8:0]             vrender,
    input  obj_types_pkg::obj_attr_t attr,
    input  logic [15:0]            obj_y,
    input  logic [15:0]            obj_code,
    input  logic [3:0]             n,
    output logic                   inzone,
    output logic [3:0]             vsub,
    output logic [15:0]            code_mn
);

    logic [8:0] offset;   // line offset inside the sprite, mod 512
    logic [8:0] zone_h;   // sprite height in lines
    logic [3:0] m;
    logic [3:0] row;

    assign offset = vrender - obj_y[8:0];
    assign zone_h = 9'(({1'b0, attr.tile_m} + 5'd1) * `OBJ_TILE_PX);
    assign inzone = offset < zone_h;

    // offset is below 256 when in zone, so bits 7:4 give the row
    assign m = offset[7:4];

    always_comb begin
        if (attr.vflip) begin
            row  = attr.tile_m - m;
            vsub = ~offset[3:0];
        end else begin
            row  = m;
            vsub = offset[3:0];
        end
    end

    // row and column add into separate nibbles, no carry across
    assign code_mn = {
        obj_code[15:8],
        obj_code[7:4] + row,
        obj_code[3:0] + n
    };

endmodule

//--- src/obj_tile_counter.sv
// horizontal tile counter
// n counts tiles left to right, npos is the screen column after hflip

module obj_tile_counter (
    input  logic       clk,
    input  logic       rst,
    input  logic       load,
    input  logic       step,
    input  logic [3:0] tile_n,
    input  logic       hflip,
    output logic [3:0] n,
    output logic [3:0] npos,
    output logic       last_col
);

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            n    <= 4'd0;
            npos <= 4'd0;
        end else if (load) begin
            n    <= 4'd0;
            npos <= hflip ? tile_n : 4'd0;  // flipped sprites start at the right
        end else if (step) begin
            n <= n + 4'd1;
            if (hflip) begin
                npos <= npos - 4'd1;
            end else begin
                npos <= npos + 4'd1;
            end
        end
    end

    assign last_col = (n == tile_n);

    // the scanner must move to the next record after the last column
    a_no_step_past_end: assert property (
        @(posedge clk) disable iff (rst)
        step |-> !last_col
    );

endmodule

//--- src/obj_line_fsm.sv
// sprite line scanner
// walks the frame table from record 255 down to 0, writes one entry
// per visible tile into the line bank and pads the rest with all ones

`include "obj_defs.svh"

module obj_line_fsm (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      start,
    input  logic [8:0]                vrender,
    output logic [`OBJ_FRAME_AW-1:0]  frame_addr,
    input  logic [15:0]               frame_data,
    input  logic                      inzone,
    output obj_types_pkg::obj_attr_t  attr,
    output logic [15:0]               obj_y,
    output logic [15:0]               obj_code,
    output logic [15:0]               obj_x,
    input  logic [15:0]               code_mn,
    input  logic [3:0]                vsub,
    output logic                      cnt_load,
    output logic                      cnt_step,
    input  logic [3:0]                npos,
    input  logic                      last_col,
    output logic                      wr_en,
    output logic [`OBJ_LINE_AW-1:0]   wr_addr,
    output obj_types_pkg::line_entry_t wr_entry,
    output logic                      done
);

    import obj_types_pkg::*;
    import obj_ctrl_pkg::*;

    scan_st_t               st;
    logic [`OBJ_LINE_AW-1:0] line_cnt;
    logic                   first;     // no predecessor for record 255
    logic                   last_rec;  // record 0 is being handled
    logic [15:0]            prev_attr;
    logic [15:0]            prev_code;
    logic [15:0]            prev_y;
    logic [15:0]            prev_x;
    logic                   repeated;
    logic                   keep;
    line_entry_t            tile_entry;

    assign repeated = (attr == prev_attr) && (obj_code == prev_code) &&
                      (obj_y == prev_y) && (obj_x == prev_x);
    assign keep     = inzone && (first || !repeated);

    // record words, the previous record is kept for the repeat test
    always_ff @(posedge clk) begin
        case (st)
            rd_attr: begin
                prev_attr <= attr;
                attr      <= frame_data;
            end
            rd_code: begin
                prev_code <= obj_code;
                obj_code  <= frame_data;
            end
            rd_y: begin
                prev_y <= obj_y;
                obj_y  <= frame_data;
            end
            rd_x: begin
                prev_x <= obj_x;
                obj_x  <= frame_data;
            end
            default: ;
        endcase
    end

    // frame_addr always points at the word latched in the following state
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            st         <= idle;
            frame_addr <= '1;   // attr word of record 255
            line_cnt   <= '0;
            first      <= 1'b0;
            last_rec   <= 1'b0;
            done       <= 1'b0;
        end else begin
            done <= 1'b0;
            case (st)
                idle: if (start) begin
                    frame_addr <= frame_addr - 1'b1;
                    line_cnt   <= '0;
                    first      <= 1'b1;
                    last_rec   <= 1'b0;
                    st         <= rd_attr;
                end
                rd_attr: begin
                    frame_addr <= frame_addr - 1'b1;
                    st         <= rd_code;
                end
                rd_code: begin
                    frame_addr <= frame_addr - 1'b1;
                    st         <= rd_y;
                end
                rd_y: begin
                    last_rec   <= (frame_addr[`OBJ_FRAME_AW-1:2] == '0);
                    frame_addr <= frame_addr - 1'b1;  // next record's attr
                    st         <= rd_x;
                end
                rd_x: st <= check;
                check: begin
                    first <= 1'b0;
                    if (keep) begin
                        st <= write;
                    end else if (last_rec) begin
                        st <= fill;
                    end else begin
                        frame_addr <= frame_addr - 1'b1;
                        st         <= rd_attr;
                    end
                end
                write: begin
                    line_cnt <= line_cnt + 1'b1;
                    if (&line_cnt) begin  // line full, stop early
                        frame_addr <= '1;
                        done       <= 1'b1;
                        st         <= idle;
                    end else begin
                        st <= next;
                    end
                end
                next: begin
                    if (!last_col) begin
                        st <= write;
                    end else if (last_rec) begin
                        st <= fill;
                    end else begin
                        frame_addr <= frame_addr - 1'b1;
                        st         <= rd_attr;
                    end
                end
                fill: begin
                    line_cnt <= line_cnt + 1'b1;
                    if (&line_cnt) begin
                        frame_addr <= '1;
                        done       <= 1'b1;
                        st         <= idle;
                    end
                end
                default: st <= idle;
            endcase
        end
    end

    // counter loads during every check, using the attr just latched
    assign cnt_load = (st == check);
    assign cnt_step = (st == next) && !last_col;

    assign tile_entry.info = {4'd0, vsub, attr[7:0]};
    assign tile_entry.code = code_mn;
    assign tile_entry.x    = obj_x + 16'(npos) * 16'(`OBJ_TILE_PX);

    assign wr_en    = (st == write) || (st == fill);
    assign wr_addr  = line_cnt;
    assign wr_entry = (st == fill) ? LINE_FILL : tile_entry;

    // slot index only counts up between start and done
    a_no_wrap: assert property (
        @(posedge clk) disable iff (rst)
        (st != idle) |=> (st == idle) || (wr_addr >= $past(wr_addr))
    );

    // done follows the write of the last slot
    a_done_src: assert property (
        @(posedge clk) disable iff (rst)
        done |-> $past(wr_en && &wr_addr)
    );

    // bank and zone test both depend on vrender staying put
    a_vrender_stable: assert property (
        @(posedge clk) disable iff (rst)
        (st != idle) |=> $stable(vrender)
    );

endmodule

//--- src/obj_line_table.sv
// sprite line table top
// frame table, double-banked line buffer, vertical match, tile counter
// and the scanner that builds one line per start pulse

`include "obj_defs.svh"

module obj_line_table (
    input  logic                       clk,
    input  logic                       rst,
    input  logic                       cpu_we,
    input  logic [`OBJ_FRAME_AW-1:0]   cpu_addr,
    input  logic [15:0]                cpu_din,
    input  logic [8:0]                 vrender,
    input  logic                       start,
    output logic                       done,
    input  logic [`OBJ_LINE_AW-1:0]    line_addr,
    output obj_types_pkg::line_entry_t line_data
);

    import obj_types_pkg::*;

    logic [`OBJ_FRAME_AW-1:0] frame_addr;
    logic [15:0]              frame_data;
    obj_attr_t                attr;
    logic [15:0]              obj_y;
    logic [15:0]              obj_code;
    logic [15:0]              obj_x;
    logic                     inzone;
    logic [3:0]               vsub;
    logic [15:0]              code_mn;
    logic                     cnt_load;
    logic                     cnt_step;
    logic [3:0]               n;
    logic [3:0]               npos;
    logic                     last_col;
    logic                     wr_en;
    logic [`OBJ_LINE_AW-1:0]  wr_addr;
    line_entry_t              wr_entry;

    obj_ram #(
        .word_t (logic [15:0]),
        .aw     (`OBJ_FRAME_AW)
    ) u_frame (
        .clk   (clk),
        .we    (cpu_we),
        .waddr (cpu_addr),
        .wdata (cpu_din),
        .raddr (frame_addr),
        .rdata (frame_data)
    );

    // build into bank vrender[0], renderer reads the other one
    obj_ram #(
        .word_t (line_entry_t),
        .aw     (`OBJ_LINE_AW + 1)
    ) u_line (
        .clk   (clk),
        .we    (wr_en),
        .waddr ({vrender[0], wr_addr}),
        .wdata (wr_entry),
        .raddr ({~vrender[0], line_addr}),
        .rdata (line_data)
    );

    obj_vmatch u_vmatch (
        .vrender  (vrender),
        .attr     (attr),
        .obj_y    (obj_y),
        .obj_code (obj_code),
        .n        (n),
        .inzone   (inzone),
        .vsub     (vsub),
        .code_mn  (code_mn)
    );

    obj_tile_counter u_cnt (
        .clk      (clk),
        .rst      (rst),
        .load     (cnt_load),
        .step     (cnt_step),
        .tile_n   (attr.tile_n),
        .hflip    (attr.hflip),
        .n        (n),
        .npos     (npos),
        .last_col (last_col)
    );

    obj_line_fsm u_fsm (
        .clk        (clk),
        .rst        (rst),
        .start      (start),
        .vrender    (vrender),
        .frame_addr (frame_addr),
        .frame_data (frame_data),
        .inzone     (inzone),
        .attr       (attr),
        .obj_y      (obj_y),
        .obj_code   (obj_code),
        .obj_x      (obj_x),
        .code_mn    (code_mn),
        .vsub       (vsub),
        .cnt_load   (cnt_load),
        .cnt_step   (cnt_step),
        .npos       (npos),
        .last_col   (last_col),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_entry   (wr_entry),
        .done       (done)
    );

endmodule

//--- verif/obj_line_table_tb.sv
// testbench for the sprite line table
// loads frame tables through the cpu port, builds lines and checks
// every entry of the finished bank against a reference model

`include "obj_defs.svh"

module obj_line_table_tb;

    import obj_types_pkg::*;

    localparam int LOAD_CYC  = 4 * `OBJ_REC_N + 4;
    localparam int LINE_CYC  = 5 * `OBJ_REC_N + 2 * `OBJ_LINE_N + 8;  // worst case scan
    localparam int READ_CYC  = `OBJ_LINE_N + 2;
    localparam int MAX_LINES = 3;                                      // lines per test
    localparam int TEST_CYC  = LOAD_CYC + MAX_LINES * (LINE_CYC + READ_CYC) + 32;
    localparam int N_TESTS   = 6;

    logic                     clk = 1'b0;
    logic                     rst;
    logic                     cpu_we;
    logic [`OBJ_FRAME_AW-1:0] cpu_addr;
    logic [15:0]              cpu_din;
    logic [8:0]               vrender;
    logic                     start;
    logic                     done;
    logic [`OBJ_LINE_AW-1:0]  line_addr;
    line_entry_t              line_data;

    logic [15:0] frame [0:4*`OBJ_REC_N-1];   // copy of what the dut table holds
    line_entry_t exp_line [0:`OBJ_LINE_N-1];
    logic [31:0] lcg_state = 32'h32e61d97;
    int          errors = 0;
    int          checks = 0;
    int          tests_ok = 0;
    int          test_err0;

    obj_line_table dut (.*);

    always #5 clk = ~clk;

    function automatic logic [31:0] rand_word();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state;
    endfunction

    function automatic logic [15:0] make_attr(input int tm, input int tn, input bit vf,
                                              input bit hf, input int pal);
        return {4'(tm), 4'(tn), 1'b0, vf, hf, 5'(pal)};
    endfunction

    task automatic set_record(input int r, input logic [15:0] a, input logic [15:0] c,
                              input logic [15:0] y, input logic [15:0] x);
        frame[4*r+3] = a;   // attr sits in the top word of a record
        frame[4*r+2] = c;
        frame[4*r+1] = y;
        frame[4*r]   = x;
    endtask

    // identical records far below any tested line
    task automatic clear_table();
        for (int r = 0; r < `OBJ_REC_N; r++) begin
            set_record(r, 16'h0000, 16'h0000, 16'h01f0, 16'h0000);
        end
    endtask

    task automatic load_table();
        for (int i = 0; i < 4 * `OBJ_REC_N; i++) begin
            @(posedge clk);
            #1;
            cpu_we   = 1'b1;
            cpu_addr = i[`OBJ_FRAME_AW-1:0];
            cpu_din  = frame[i];
        end
        @(posedge clk);
        #1;
        cpu_we = 1'b0;
    endtask

    // expected bank for line v, highest record first
    task automatic compute_expected(input logic [8:0] v);
        int          cnt;
        int          base;
        obj_attr_t   a;
        logic [15:0] c;
        logic [15:0] y;
        logic [15:0] x;
        logic [8:0]  off;
        logic [3:0]  row;
        logic [3:0]  vs;
        logic [3:0]  col;
        cnt = 0;
        for (int i = 0; i < `OBJ_LINE_N; i++) begin
            exp_line[i] = LINE_FILL;
        end
        for (int r = `OBJ_REC_N - 1; r >= 0; r--) begin
            base = 4 * r;
            a    = frame[base+3];
            c    = frame[base+2];
            y    = frame[base+1];
            x    = frame[base];
            off  = v - y[8:0];
            if (r < `OBJ_REC_N - 1 && frame[base+7] == a && frame[base+6] == c &&
                frame[base+5] == y && frame[base+4] == x) begin
                continue;   // repeat of the record above
            end
            if (int'(off) >= 16 * (int'(a.tile_m) + 1)) begin
                continue;
            end
            row = 4'(off / 16);
            vs  = 4'(off % 16);
            if (a.vflip) begin
                row = a.tile_m - row;
                vs  = 4'd15 - vs;
            end
            for (int n = 0; n <= int'(a.tile_n); n++) begin
                if (cnt < `OBJ_LINE_N) begin
                    col = a.hflip ? a.tile_n - 4'(n) : 4'(n);
                    exp_line[cnt].info = {4'd0, vs, a[7:0]};
                    exp_line[cnt].code = {c[15:8], c[7:4] + row, c[3:0] + 4'(n)};
                    exp_line[cnt].x    = x + 16'(col) * 16'd16;
                    cnt++;
                end
            end
        end
    endtask

    task automatic start_line(input logic [8:0] v);
        @(posedge clk);
        #1;
        vrender = v;
        start   = 1'b1;
        @(posedge clk);
        #1;
        start = 1'b0;
    endtask

    task automatic wait_line_done();
        int cyc;
        int pulses;
        cyc = 0;
        while (!done && cyc < LINE_CYC) begin
            @(posedge clk);
            #1;
            cyc++;
        end
        if (!done) begin
            $display("no done pulse from the scanner within %0d cycles of start", LINE_CYC);
            errors++;
        end else begin
            pulses = 1;
            repeat (4) begin
                @(posedge clk);
                #1;
                if (done) pulses++;
            end
            checks++;
            assert (pulses == 1) else begin
                $display("Fail %0t done pulses expected 1 got %0d", $time, pulses);
                errors++;
            end
        end
    endtask

    // reads the bank opposite to vrender[0], one cycle read latency
    task automatic check_bank();
        for (int i = 0; i <= `OBJ_LINE_N; i++) begin
            @(posedge clk);
            #1;
            if (i > 0) begin
                checks++;
                assert (line_data == exp_line[i-1]) else begin
                    $display("Fail %0t line_data[%0d] expected %h got %h",
                             $time, i - 1, exp_line[i-1], line_data);
                    errors++;
                end
            end
            if (i < `OBJ_LINE_N) begin
                line_addr = i[`OBJ_LINE_AW-1:0];
            end
        end
    endtask

    task automatic build_and_check(input logic [8:0] v);
        compute_expected(v);
        start_line(v);
        wait_line_done();
        vrender = v + 9'd1;   // renderer moves on, built bank becomes readable
        check_bank();
    endtask

    task automatic end_test(input int num, input string name);
        $display("test %0d %s: %s", num, name, (errors == test_err0) ? "ok" : "errors");
        if (errors == test_err0) tests_ok++;
        test_err0 = errors;
    endtask

    initial begin
        logic [31:0] rnd;
        int          r;
        rst       = 1'b1;
        cpu_we    = 1'b0;
        cpu_addr  = '0;
        cpu_din   = '0;
        vrender   = '0;
        start     = 1'b0;
        line_addr = '0;
        repeat (16) @(posedge clk);
        #1;
        rst       = 1'b0;
        test_err0 = 0;

        // 3 columns by 2 rows, only row 0 on line 10
        clear_table();
        set_record(200, make_attr(1, 2, 0, 0, 4), 16'h1230, 16'd5, 16'h0040);
        load_table();
        build_and_check(9'd10);
        end_test(1, "single sprite");

        clear_table();
        set_record(100, make_attr(0, 2, 0, 1, 3), 16'h0500, 16'd17, 16'h0100);
        set_record(99, make_attr(1, 0, 1, 0, 7), 16'h0700, 16'd0, 16'h0030);
        load_table();
        build_and_check(9'd20);
        end_test(2, "flips");

        clear_table();
        set_record(60, make_attr(0, 1, 0, 0, 1), 16'h0a00, 16'd40, 16'h0020);
        set_record(59, make_attr(0, 1, 0, 0, 1), 16'h0a00, 16'd40, 16'h0020);
        set_record(58, make_attr(0, 1, 0, 0, 2), 16'h0b00, 16'd100, 16'h0050);
        set_record(57, make_attr(0, 1, 0, 0, 1), 16'h0a00, 16'd40, 16'h0080);
        load_table();
        build_and_check(9'd40);
        end_test(3, "zone and repeat");

        // 10 sprites of 16 tiles overflow the 128 slots
        clear_table();
        for (int k = 10; k < 20; k++) begin
            set_record(k, make_attr(0, 15, 0, 0, k), 16'(k << 8), 16'd60, 16'(k * 300));
        end
        load_table();
        build_and_check(9'd60);
        end_test(4, "full line");

        // top records, so line 11 entries land early in the scan
        clear_table();
        set_record(255, make_attr(0, 1, 0, 0, 2), 16'h0c00, 16'd5, 16'h0010);
        set_record(254, make_attr(0, 0, 0, 0, 9), 16'h0d00, 16'd11, 16'h0090);
        load_table();
        build_and_check(9'd10);
        start_line(9'd11);
        check_bank();   // line 10 bank read while line 11 is built
        check_bank();   // again, after the first line 11 writes
        wait_line_done();
        compute_expected(9'd11);
        vrender = 9'd12;
        check_bank();
        end_test(5, "bank isolation");

        clear_table();
        for (int k = 0; k < 40; k++) begin
            rnd = rand_word();
            r   = int'(rnd[31:24]);
            if (k % 5 == 4 && r < `OBJ_REC_N - 1) begin
                set_record(r, frame[4*r+7], frame[4*r+6], frame[4*r+5], frame[4*r+4]);
            end else begin
                set_record(r, {2'b00, rnd[13:12], 1'b0, rnd[10:0]}, rand_word() >> 16,
                           {rnd[22:16], 9'd100 - 9'(rnd[5:0])}, rand_word() >> 8);
            end
        end
        load_table();
        build_and_check(9'd100);
        build_and_check(9'd101);
        build_and_check(9'd102);
        end_test(6, "random tables");

        $display("tests %0d, ok %0d, with errors %0d, checks %0d, errors %0d",
                 N_TESTS, tests_ok, N_TESTS - tests_ok, checks, errors);
        if (errors == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

    initial begin
        #((16 + N_TESTS * TEST_CYC) * 10);
        $display("watchdog expired, the run hung before all tests finished");
        $display("test failed");
        $finish;
    end

endmodule

//--- src.f
+incdir+include
src/obj_types_pkg.sv
src/obj_ctrl_pkg.sv
src/obj_ram.sv
src/obj_vmatch.sv
src/obj_tile_counter.sv
src/obj_line_fsm.sv
src/obj_line_table.sv
verif/obj_line_table_tb.sv

//--- Makefile
SRCS := $(wildcard src/*.sv) $(wildcard verif/*.sv) $(wildcard include/*.svh)

all: run

obj_dir/Vobj_line_table_tb: $(SRCS) src.f
	verilator --binary --timing --assert -Wno-fatal -f src.f \
		--top-module obj_line_table_tb -o Vobj_line_table_tb

run: obj_dir/Vobj_line_table_tb
	./obj_dir/Vobj_line_table_tb | tee sim.log
	@grep -q "^test passed$$" sim.log

clean:
	rm -rf obj_dir sim.log

.PHONY: all run clean
